/* rtl/uart_rx_pkg.sv */
package uart_rx_pkg;

	// serial word geometry
	localparam int BYTE_W = 8;
	// start bit, data bits, stop bit
	localparam int FRAME_W = BYTE_W + 2;

	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [7:0] period_t;
	// bit 8 is the frame error, bits 7..0 the data
	typedef logic [BYTE_W:0] rx_word_t;
	typedef logic [1:0] reg_addr_t;

	// register map, address 3 reads as zero
	localparam reg_addr_t ADDR_PERIOD = 2'd0;
	localparam reg_addr_t ADDR_RX_DATA = 2'd1;
	localparam reg_addr_t ADDR_CONTROL = 2'd2;

	// control word bits
	localparam int CTRL_RXEN = 0;
	localparam int CTRL_DATA_READY = 1;
	localparam int CTRL_OVERRUN = 2;

	// receive FIFO
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_ADDR_W = 3;

	// oversampling
	localparam int OVERSAMPLE = 16;
	localparam int SAMPLE_POINT = 8;
	localparam int TICK_W = $clog2(OVERSAMPLE);
	localparam int BIT_CNT_W = $clog2(BYTE_W);

	typedef enum logic [2:0] {
		RX_OFF,
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

endpackage

/* rtl/baud_gen.sv */
module baud_gen import uart_rx_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  byte_t   din,
	input  logic    period_wr,
	output period_t period_q,
	output logic    baud_tick
);

	period_t count;

	// divisor register, readable by the host
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			period_q <= '0;
		end else if (period_wr) begin
			period_q <= period_t'(din);
		end
	end

	// down-counter, one tick per wrap
	// a write restarts the count from the new divisor
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= '0;
			baud_tick <= 1'b0;
		end else if (period_wr) begin
			count <= period_t'(din);
			baud_tick <= 1'b0;
		end else if (count == '0) begin
			count <= period_q;
			baud_tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			baud_tick <= 1'b0;
		end
	end

endmodule

/* rtl/rx_deframer.sv */
module rx_deframer import uart_rx_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     rxd,
	input  logic     baud_tick,
	input  logic     receive_enable,
	output logic     frame_valid,
	output rx_word_t frame_word
);

	logic rxd_meta;
	logic rxd_sync;
	logic rxd_prev;
	rx_state_t state;
	logic [TICK_W-1:0] tick_cnt;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [FRAME_W-1:0] shift;
	logic start_edge;
	logic mid_tick;
	logic bit_tick;
	logic sample_en;

	// two-flop synchronizer, line idles high
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxd_meta <= 1'b1;
			rxd_sync <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= rxd;
			rxd_sync <= rxd_meta;
			rxd_prev <= rxd_sync;
		end
	end

	assign start_edge = rxd_prev & ~rxd_sync;

	// start bit checked half a bit in, later bits a full bit apart
	assign mid_tick = baud_tick && (tick_cnt == TICK_W'(SAMPLE_POINT - 1));
	assign bit_tick = baud_tick && (tick_cnt == TICK_W'(OVERSAMPLE - 1));

	assign sample_en = (state == RX_START && mid_tick && !rxd_sync) ||
		((state == RX_DATA || state == RX_STOP) && bit_tick);

	// lsb first, so after ten samples the start bit sits in bit 0
	always_ff @(posedge clk) begin
		if (sample_en) begin
			shift <= {rxd_sync, shift[FRAME_W-1:1]};
		end
	end

	// stop bit low means a framing error
	assign frame_word = {~shift[FRAME_W-1], shift[FRAME_W-2:1]};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= RX_OFF;
			tick_cnt <= '0;
			bit_cnt <= '0;
			frame_valid <= 1'b0;
		end else begin
			frame_valid <= 1'b0;
			if (!receive_enable) begin
				state <= RX_OFF;
				tick_cnt <= '0;
				bit_cnt <= '0;
			end else begin
				case (state)
					RX_OFF: begin
						state <= RX_IDLE;
					end
					RX_IDLE: begin
						if (start_edge) begin
							tick_cnt <= '0;
							state <= RX_START;
						end
					end
					RX_START: begin
						if (mid_tick) begin
							tick_cnt <= '0;
							bit_cnt <= '0;
							// a high line here was only a glitch
							state <= rxd_sync ? RX_IDLE : RX_DATA;
						end else if (baud_tick) begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					RX_DATA: begin
						if (bit_tick) begin
							tick_cnt <= '0;
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == BIT_CNT_W'(BYTE_W - 1)) begin
								state <= RX_STOP;
							end
						end else if (baud_tick) begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					RX_STOP: begin
						if (bit_tick) begin
							tick_cnt <= '0;
							frame_valid <= 1'b1;
							state <= RX_IDLE;
						end else if (baud_tick) begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					default: begin
						state <= RX_OFF;
					end
				endcase
			end
		end
	end

endmodule

/* rtl/rx_fifo.sv */
module rx_fifo import uart_rx_pkg::*; (
	input  logic     clk,
	input  logic     reset,
	input  logic     flush,
	input  logic     push,
	input  logic     pop,
	input  rx_word_t push_word,
	output rx_word_t fifo_word,
	output logic     fifo_empty,
	output logic     fifo_full
);

	rx_word_t mem [FIFO_DEPTH];
	logic [FIFO_ADDR_W-1:0] rd_ptr;
	logic [FIFO_ADDR_W-1:0] wr_ptr;
	logic [FIFO_ADDR_W:0] count;
	logic do_push;
	logic do_pop;

	assign fifo_empty = (count == '0);
	assign fifo_full = (count == (FIFO_ADDR_W + 1)'(FIFO_DEPTH));

	// flush wins over both push and pop
	assign do_push = push && !fifo_full && !flush;
	assign do_pop = pop && !fifo_empty && !flush;

	// fall-through head
	assign fifo_word = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_word;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else if (flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* rtl/uart_rx_regs.sv */
module uart_rx_regs import uart_rx_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  reg_addr_t addr,
	input  logic      wren,
	input  logic      rden,
	input  byte_t     din,
	input  period_t   period_q,
	input  rx_word_t  fifo_word,
	input  logic      fifo_empty,
	input  logic      fifo_full,
	input  logic      frame_valid,
	output logic      period_wr,
	output logic      fifo_pop,
	output logic      receive_enable,
	output logic      fifo_flush,
	output rx_word_t  dout
);

	logic ctrl_wr;
	logic rxen;
	logic rxen_next;
	logic data_ready;
	logic overrun;
	rx_word_t ctrl_word;

	// write and read strobes
	assign period_wr = wren && (addr == ADDR_PERIOD);
	assign ctrl_wr = wren && (addr == ADDR_CONTROL);
	assign fifo_pop = rden && (addr == ADDR_RX_DATA);

	assign rxen_next = ctrl_wr ? din[CTRL_RXEN] : rxen;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxen <= 1'b0;
			data_ready <= 1'b0;
			overrun <= 1'b0;
		end else begin
			rxen <= rxen_next;
			data_ready <= rxen_next && !fifo_empty;
			// sticky until the host drops the enable
			overrun <= rxen_next && (overrun || (frame_valid && fifo_full));
		end
	end

	// receiver halts on overrun, FIFO held empty while disabled
	assign receive_enable = rxen && !overrun;
	assign fifo_flush = !rxen;

	always_comb begin
		ctrl_word = '0;
		ctrl_word[CTRL_RXEN] = rxen;
		ctrl_word[CTRL_DATA_READY] = data_ready;
		ctrl_word[CTRL_OVERRUN] = overrun;
	end

	// read mux, zero unless rden
	always_comb begin
		dout = '0;
		if (rden) begin
			case (addr)
				ADDR_PERIOD: dout = rx_word_t'(period_q);
				ADDR_RX_DATA: dout = fifo_word;
				ADDR_CONTROL: dout = ctrl_word;
				default: dout = '0;
			endcase
		end
	end

endmodule

/* rtl/uart_rx.sv */
module uart_rx import uart_rx_pkg::*; (
	input  logic      clk,
	input  logic      reset,
	input  reg_addr_t addr,
	input  logic      wren,
	input  logic      rden,
	input  byte_t     din,
	input  logic      rxd,
	output rx_word_t  dout
);

	logic period_wr;
	period_t period_q;
	logic baud_tick;
	logic receive_enable;
	logic frame_valid;
	rx_word_t frame_word;
	logic fifo_flush;
	logic fifo_pop;
	rx_word_t fifo_word;
	logic fifo_empty;
	logic fifo_full;

	baud_gen baud_gen_i (
		.clk       (clk),
		.reset     (reset),
		.din       (din),
		.period_wr (period_wr),
		.period_q  (period_q),
		.baud_tick (baud_tick)
	);

	rx_deframer rx_deframer_i (
		.clk            (clk),
		.reset          (reset),
		.rxd            (rxd),
		.baud_tick      (baud_tick),
		.receive_enable (receive_enable),
		.frame_valid    (frame_valid),
		.frame_word     (frame_word)
	);

	// a frame arriving at a full FIFO is dropped inside the FIFO
	rx_fifo rx_fifo_i (
		.clk        (clk),
		.reset      (reset),
		.flush      (fifo_flush),
		.push       (frame_valid),
		.pop        (fifo_pop),
		.push_word  (frame_word),
		.fifo_word  (fifo_word),
		.fifo_empty (fifo_empty),
		.fifo_full  (fifo_full)
	);

	uart_rx_regs uart_rx_regs_i (
		.clk            (clk),
		.reset          (reset),
		.addr           (addr),
		.wren           (wren),
		.rden           (rden),
		.din            (din),
		.period_q       (period_q),
		.fifo_word      (fifo_word),
		.fifo_empty     (fifo_empty),
		.fifo_full      (fifo_full),
		.frame_valid    (frame_valid),
		.period_wr      (period_wr),
		.fifo_pop       (fifo_pop),
		.receive_enable (receive_enable),
		.fifo_flush     (fifo_flush),
		.dout           (dout)
	);

endmodule

/* tb/uart_rx_properties.sv */
module uart_rx_properties import uart_rx_pkg::*; (
	input logic      clk,
	input logic      reset,
	input reg_addr_t addr,
	input logic      rden,
	input rx_word_t  dout,
	input logic      frame_valid,
	input logic      receive_enable,
	input logic      fifo_pop,
	input logic      fifo_flush,
	input logic      fifo_full,
	input logic      fifo_empty,
	input rx_word_t  fifo_word
);

	int fail_count = 0;
	logic halted;

	// enabled but stopped, which only an overrun causes
	assign halted = !fifo_flush && !receive_enable;

	frame_valid_pulse: assert property (@(posedge clk) disable iff (reset)
		frame_valid |=> !frame_valid)
	else begin
		$error("frame_valid lasted more than one cycle");
		fail_count++;
	end

	// a dropped frame leaves the full FIFO untouched
	no_push_when_full: assert property (@(posedge clk) disable iff (reset)
		(frame_valid && fifo_full && !fifo_pop && !fifo_flush) |=>
		(fifo_full && $stable(fifo_word)))
	else begin
		$error("frame written into a full FIFO");
		fail_count++;
	end

	no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
		(fifo_pop && fifo_empty && !frame_valid && !fifo_flush) |=> fifo_empty)
	else begin
		$error("pop from an empty FIFO changed its state");
		fail_count++;
	end

	overrun_sticky: assert property (@(posedge clk) disable iff (reset)
		halted |=> (halted || fifo_flush))
	else begin
		$error("overrun cleared while RXEN was still set");
		fail_count++;
	end

	quiet_when_disabled: assert property (@(posedge clk) disable iff (reset)
		!receive_enable |=> !frame_valid)
	else begin
		$error("frame reported with the receiver disabled");
		fail_count++;
	end

	reset_state: assert property (@(posedge clk)
		$fell(reset) |-> (fifo_flush && !receive_enable && fifo_empty))
	else begin
		$error("control state not cleared by reset");
		fail_count++;
	end

	// with RXEN clear the whole control word is zero
	ctrl_zero_when_off: assert property (@(posedge clk) disable iff (reset)
		(rden && addr == ADDR_CONTROL && fifo_flush) |-> (dout == '0))
	else begin
		$error("control word nonzero while RXEN is clear");
		fail_count++;
	end

endmodule

bind uart_rx uart_rx_properties uart_rx_properties_i (
	.clk            (clk),
	.reset          (reset),
	.addr           (addr),
	.rden           (rden),
	.dout           (dout),
	.frame_valid    (frame_valid),
	.receive_enable (receive_enable),
	.fifo_pop       (fifo_pop),
	.fifo_flush     (fifo_flush),
	.fifo_full      (fifo_full),
	.fifo_empty     (fifo_empty),
	.fifo_word      (fifo_word)
);

/* tb/uart_rx_tb.sv */
module uart_rx_tb import uart_rx_pkg::*; ();

	// period 3 gives a tick every 4 clocks
	localparam int BIT_CLOCKS = 4 * OVERSAMPLE;

	logic clk;
	logic reset;
	reg_addr_t addr;
	logic wren;
	logic rden;
	byte_t din;
	logic rxd;
	rx_word_t dout;

	int errors;
	int prop_errors;
	integer seed;
	byte_t sent [$];

	uart_rx uart_rx_i (
		.clk   (clk),
		.reset (reset),
		.addr  (addr),
		.wren  (wren),
		.rden  (rden),
		.din   (din),
		.rxd   (rxd),
		.dout  (dout)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// control word as the host should see it
	function automatic rx_word_t ctrl_value(input logic en, input logic ready, input logic ovr);
		rx_word_t w;
		w = '0;
		w[CTRL_RXEN] = en;
		w[CTRL_DATA_READY] = ready;
		w[CTRL_OVERRUN] = ovr;
		return w;
	endfunction

	function automatic byte_t random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic reg_write(input reg_addr_t a, input byte_t d);
		@(posedge clk);
		addr <= a;
		din <= d;
		wren <= 1'b1;
		@(posedge clk);
		wren <= 1'b0;
	endtask

	// one-cycle read, sampled mid-cycle
	task automatic reg_read(input reg_addr_t a, output rx_word_t value);
		@(posedge clk);
		addr <= a;
		rden <= 1'b1;
		@(negedge clk);
		value = dout;
		@(posedge clk);
		rden <= 1'b0;
	endtask

	task automatic check_read(input string name, input reg_addr_t a, input rx_word_t expected);
		rx_word_t value;
		reg_read(a, value);
		assert (value === expected) else begin
			$display("FAIL %s: expected %h, got %h", name, expected, value);
			errors++;
		end
	endtask

	task automatic poll_ctrl_bit(input int bit_pos, input string what);
		rx_word_t value;
		int tries;
		tries = 0;
		value = '0;
		while (!value[bit_pos] && tries < 400) begin
			reg_read(ADDR_CONTROL, value);
			tries++;
		end
		if (!value[bit_pos]) begin
			$display("timeout while waiting for %s", what);
			errors++;
		end
	endtask

	// start bit, data lsb first, stop bit
	task automatic send_frame(input byte_t data, input logic stop_good);
		logic [FRAME_W-1:0] bits;
		bits = {stop_good, data, 1'b0};
		for (int i = 0; i < FRAME_W; i++) begin
			@(posedge clk);
			rxd <= bits[i];
			repeat (BIT_CLOCKS - 1) @(posedge clk);
		end
		@(posedge clk);
		rxd <= 1'b1;
		// line must idle high before another start edge
		if (!stop_good) begin
			repeat (BIT_CLOCKS) @(posedge clk);
		end
	endtask

	initial begin
		byte_t b;
		rx_word_t value;
		errors = 0;
		seed = 32'h0651_95c2;
		reset <= 1'b1;
		addr <= ADDR_PERIOD;
		wren <= 1'b0;
		rden <= 1'b0;
		din <= '0;
		rxd <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		check_read("reset_control", ADDR_CONTROL, ctrl_value(1'b0, 1'b0, 1'b0));
		reg_write(ADDR_PERIOD, 8'd3);
		check_read("period_readback", ADDR_PERIOD, 9'd3);
		reg_write(ADDR_CONTROL, 8'h01);

		b = random_byte();
		send_frame(b, 1'b1);
		poll_ctrl_bit(CTRL_DATA_READY, "data ready after a good frame");
		check_read("good_frame", ADDR_RX_DATA, {1'b0, b});
		check_read("ready_cleared", ADDR_CONTROL, ctrl_value(1'b1, 1'b0, 1'b0));
		// extra pop on an empty FIFO
		reg_read(ADDR_RX_DATA, value);

		b = random_byte();
		send_frame(b, 1'b0);
		poll_ctrl_bit(CTRL_DATA_READY, "data ready after a bad stop bit");
		check_read("bad_stop", ADDR_RX_DATA, {1'b1, b});

		sent.delete();
		for (int i = 0; i < 4; i++) begin
			b = random_byte();
			sent.push_back(b);
			send_frame(b, 1'b1);
		end
		poll_ctrl_bit(CTRL_DATA_READY, "data ready after a burst");
		for (int i = 0; i < 4; i++) begin
			check_read("burst_order", ADDR_RX_DATA, {1'b0, sent[i]});
		end

		// one frame more than the FIFO holds
		sent.delete();
		for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
			b = random_byte();
			sent.push_back(b);
			send_frame(b, 1'b1);
		end
		poll_ctrl_bit(CTRL_OVERRUN, "overrun");
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			check_read("overrun_data", ADDR_RX_DATA, {1'b0, sent[i]});
		end
		check_read("overrun_drained", ADDR_CONTROL, ctrl_value(1'b1, 1'b0, 1'b1));
		reg_write(ADDR_CONTROL, 8'h00);
		check_read("overrun_cleared", ADDR_CONTROL, ctrl_value(1'b0, 1'b0, 1'b0));
		reg_write(ADDR_CONTROL, 8'h01);
		b = random_byte();
		send_frame(b, 1'b1);
		poll_ctrl_bit(CTRL_DATA_READY, "data ready after re-enable");
		check_read("after_overrun", ADDR_RX_DATA, {1'b0, b});

		// receiver off with a byte pending, then a frame ignored
		send_frame(random_byte(), 1'b1);
		poll_ctrl_bit(CTRL_DATA_READY, "data ready before disable");
		reg_write(ADDR_CONTROL, 8'h00);
		send_frame(random_byte(), 1'b1);
		check_read("disabled_ready", ADDR_CONTROL, ctrl_value(1'b0, 1'b0, 1'b0));
		reg_write(ADDR_CONTROL, 8'h01);
		check_read("disabled_empty", ADDR_CONTROL, ctrl_value(1'b1, 1'b0, 1'b0));

		prop_errors = uart_rx_i.uart_rx_properties_i.fail_count;
		$display("errors: %0d in checks, %0d in assertions", errors, prop_errors);
		if (errors == 0 && prop_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* compile.f */
rtl/uart_rx_pkg.sv
rtl/baud_gen.sv
rtl/rx_deframer.sv
rtl/rx_fifo.sv
rtl/uart_rx_regs.sv
rtl/uart_rx.sv
tb/uart_rx_properties.sv
tb/uart_rx_tb.sv

/* Makefile */
TOP = uart_rx_tb
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir $(OBJ)

run: compile
	./$(OBJ)/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf $(OBJ) sim.log
